// ==== mips_core.f ====
rtl/mips_pkg.sv
rtl/mips_decode.sv
rtl/mips_regfile.sv
rtl/mips_alu.sv
rtl/mips_mem_align.sv
rtl/mips_core.sv
tb/mips_core_sva.sv
tb/mips_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= mips_core.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/mips_core_tb.sv ====
`timescale 1ns/10ps

module mips_core_tb;

   localparam int          MAX_PROG = 512;
   localparam int          MEM_WORDS = 64;
   localparam logic [31:0] SEED = 32'hd643e6af;
   localparam mips_pkg::waddr_t BASE_WA = mips_pkg::RESET_PC[31:2];

   logic                  clk;
   logic                  rst_b;
   mips_pkg::word_t       inst;
   mips_pkg::word_t       mem_data_out;
   mips_pkg::waddr_t      inst_addr;
   mips_pkg::waddr_t      mem_addr;
   mips_pkg::word_t       mem_data_in;
   mips_pkg::byte_en_t    mem_write_en;

   mips_pkg::word_t  prog [0:MAX_PROG-1];   // program table
   int               tag [0:MAX_PROG-1];    // test number of each entry
   mips_pkg::word_t  mem [0:MEM_WORDS-1];
   mips_pkg::word_t  model_mem [0:MEM_WORDS-1];
   // expected stores from the reference model
   mips_pkg::waddr_t   exp_addr [0:MAX_PROG-1];
   mips_pkg::byte_en_t exp_en [0:MAX_PROG-1];
   mips_pkg::word_t    exp_data [0:MAX_PROG-1];
   int                 exp_cyc [0:MAX_PROG-1];
   int                 exp_tag [0:MAX_PROG-1];
   int n_prog = 0;
   int n_exp = 0;
   int slot = 0;     // next result word for sw
   int p = 0;        // next expected store
   int cyc = 0;      // edges since reset release
   int chk [1:6];
   int err [1:6];
   logic run = 1'b0;
   logic built = 1'b0;
   logic [5:0] fns [0:7] = '{mips_pkg::FN_ADDU, mips_pkg::FN_SUBU, mips_pkg::FN_AND,
                            mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
                            mips_pkg::FN_SLT, mips_pkg::FN_SLTU};
   logic [29:0] fetch_off;

   mips_core dut0 (.clk(clk), .rst_b(rst_b), .inst(inst), .mem_data_out(mem_data_out),
                   .inst_addr(inst_addr), .mem_addr(mem_addr), .mem_data_in(mem_data_in),
                   .mem_write_en(mem_write_en));

   bind mips_core mips_core_sva sva0 (.clk(clk), .rst_b(rst_b), .inst_addr(inst_addr),
                                      .mem_write_en(mem_write_en));

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // instruction and data memories answer in the same cycle
   assign fetch_off    = inst_addr - BASE_WA;
   assign inst         = (fetch_off < 30'(n_prog)) ? prog[fetch_off[8:0]] : '0;  // nop past end
   assign mem_data_out = mem[mem_addr[5:0]];

   always @(posedge clk)
   begin
      for (int k = 0; k < 4; k++)
         if (mem_write_en[k])
            mem[mem_addr[5:0]][8*k +: 8] <= mem_data_in[8*k +: 8];
   end

   always @(posedge clk)
      if (rst_b)
         cyc <= cyc + 1;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic lsb;
      lsb = s[0];
      s = s >> 1;
      if (lsb)
         s = s ^ 32'ha300_0000;   // taps 32 30 26 25
      return s;
   endfunction

   function automatic mips_pkg::word_t lane_mask(input mips_pkg::byte_en_t en);
      mips_pkg::word_t m;
      for (int k = 0; k < 4; k++)
         m[8*k +: 8] = {8{en[k]}};
      return m;
   endfunction

   function automatic mips_pkg::word_t rtype(input logic [5:0] fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] sh);
      return {mips_pkg::OP_SPECIAL, rs, rt, rd, sh, fn};
   endfunction

   function automatic mips_pkg::word_t itype(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // every entry is followed by two nops so a consumer is three slots later
   task automatic put(input mips_pkg::word_t w, input int t);
      prog[n_prog] = w;
      tag[n_prog] = t;
      prog[n_prog+1] = '0;
      tag[n_prog+1] = t;
      prog[n_prog+2] = '0;
      tag[n_prog+2] = t;
      n_prog += 3;
   endtask

   task automatic keep(input logic [4:0] r, input int t);
      put(itype(mips_pkg::OP_SW, 5'd0, r, 16'(slot * 4)), t);
      slot++;
   endtask

   task automatic check_value(input int t, input string sig, input mips_pkg::word_t expv,
                              input mips_pkg::word_t obsv);
      chk[t]++;
      if (expv !== obsv)
      begin
         $display("** Error at %0d ns: %s expected %h observed %h", $time, sig, expv, obsv);
         err[t]++;
      end
   endtask

   // sequential ISA interpreter that holds since consumers sit three slots after producers
   task automatic run_model();
      mips_pkg::word_t r [0:31];
      mips_pkg::word_t w, a, b, se, res, addr, word, data, sh_w, m;
      mips_pkg::byte_en_t en;
      logic [5:0] op;
      logic [4:0] sh;
      logic [4:0] dst;
      logic [1:0] lo;
      logic wr;
      for (int i = 0; i < 32; i++)
         r[i] = '0;
      for (int i = 0; i < n_prog; i++)
      begin
         w = prog[i];
         op = w[31:26];
         sh = w[10:6];
         a = r[w[25:21]];
         b = r[w[20:16]];
         se = {{16{w[15]}}, w[15:0]};
         addr = a + se;
         lo = addr[1:0];
         word = model_mem[addr[7:2]];
         wr = 1'b1;
         dst = w[20:16];
         res = '0;
         en = 4'b0000;
         data = b;
         case (op)
            mips_pkg::OP_SPECIAL:
            begin
               dst = w[15:11];
               case (w[5:0])
                  mips_pkg::FN_ADDU: res = a + b;
                  mips_pkg::FN_SUBU: res = a - b;
                  mips_pkg::FN_AND:  res = a & b;
                  mips_pkg::FN_OR:   res = a | b;
                  mips_pkg::FN_XOR:  res = a ^ b;
                  mips_pkg::FN_NOR:  res = ~(a | b);
                  mips_pkg::FN_SLT:  res = {31'd0, ($signed(a) < $signed(b))};
                  mips_pkg::FN_SLTU: res = {31'd0, (a < b)};
                  mips_pkg::FN_SLL:  res = b << sh;
                  mips_pkg::FN_SRL:  res = b >> sh;
                  mips_pkg::FN_SRA:  res = $signed(b) >>> sh;
                  mips_pkg::FN_SLLV: res = b << a[4:0];
                  mips_pkg::FN_SRLV: res = b >> a[4:0];
                  mips_pkg::FN_SRAV: res = $signed(b) >>> a[4:0];
                  default:           wr = 1'b0;
               endcase
            end
            mips_pkg::OP_ADDIU: res = a + se;
            mips_pkg::OP_SLTI:  res = {31'd0, ($signed(a) < $signed(se))};
            mips_pkg::OP_ANDI:  res = a & {16'h0000, w[15:0]};
            mips_pkg::OP_ORI:   res = a | {16'h0000, w[15:0]};
            mips_pkg::OP_XORI:  res = a ^ {16'h0000, w[15:0]};
            mips_pkg::OP_LUI:   res = {w[15:0], 16'h0000};
            mips_pkg::OP_LB, mips_pkg::OP_LBU:
            begin
               sh_w = word >> {lo, 3'b000};
               res = {(op == mips_pkg::OP_LB) ? {24{sh_w[7]}} : 24'd0, sh_w[7:0]};
            end
            mips_pkg::OP_LH, mips_pkg::OP_LHU:
            begin
               sh_w = word >> {lo[1], 4'b0000};
               res = {(op == mips_pkg::OP_LH) ? {16{sh_w[15]}} : 16'd0, sh_w[15:0]};
            end
            mips_pkg::OP_LW:    res = word;
            mips_pkg::OP_SB:
            begin
               wr = 1'b0;
               en = 4'b0001 << lo;
               data = {24'd0, b[7:0]} << {lo, 3'b000};
            end
            mips_pkg::OP_SH:
            begin
               wr = 1'b0;
               en = 4'b0011 << {lo[1], 1'b0};
               data = {16'd0, b[15:0]} << {lo[1], 4'b0000};
            end
            mips_pkg::OP_SW:
            begin
               wr = 1'b0;
               en = 4'b1111;
            end
            default: wr = 1'b0;   // opcode not kept acts as a no-op
         endcase
         if (en != 4'b0000)
         begin
            m = lane_mask(en);
            model_mem[addr[7:2]] = (word & ~m) | (data & m);
            exp_addr[n_exp] = addr[31:2];
            exp_en[n_exp] = en;
            exp_data[n_exp] = data;
            exp_cyc[n_exp] = i + 3;   // captured at edge i+1 with strobes after edge i+3
            exp_tag[n_exp] = tag[i];
            n_exp++;
         end
         if (wr && (dst != 5'd0))
            r[dst] = res;
      end
   endtask

   // store port and fetch checks sampled on the falling edge
   always @(negedge clk)
   begin
      if (run)
      begin
         check_value(1, "inst_addr", {2'b00, BASE_WA + 30'(cyc)}, {2'b00, inst_addr});
         if (mem_write_en != 4'b0000)
         begin
            if (p >= n_exp)
            begin
               $display("store seen at %0d ns with no store expected", $time);
               err[6]++;
            end
            else
            begin
               check_value(exp_tag[p], "mem_addr", {2'b00, exp_addr[p]}, {2'b00, mem_addr});
               check_value(exp_tag[p], "mem_write_en", {28'd0, exp_en[p]},
                           {28'd0, mem_write_en});
               check_value(exp_tag[p], "mem_data_in", exp_data[p] & lane_mask(exp_en[p]),
                           mem_data_in & lane_mask(exp_en[p]));
               check_value(6, "store cycle", exp_cyc[p], cyc);
               p++;
            end
         end
      end
   end

   initial
   begin
      wait (built);
      repeat (n_prog + 20) #20;
      $display("watchdog timeout, the program did not finish in time");
      $display("Result: FAILED");
      $finish;
   end

   initial
   begin
      logic [31:0] lfsr;
      int total_chk;
      int total_err;
      rst_b = 1'b0;
      lfsr = SEED;
      for (int t = 1; t <= 6; t++)
      begin
         chk[t] = 0;
         err[t] = 0;
      end
      for (int i = 0; i < MEM_WORDS; i++)
         for (int k = 0; k < 32; k++)
         begin
            mem[i][k] = lfsr[0];   // one step per bit
            lfsr = lfsr_step(lfsr);
         end
      // alu, immediate and r-type
      put(itype(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h1234), 2);
      put(itype(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'hfffb), 2);
      put(itype(mips_pkg::OP_ORI, 5'd0, 5'd3, 16'hf0f0), 2);
      put(itype(mips_pkg::OP_ANDI, 5'd2, 5'd12, 16'hf00f), 2);
      put(itype(mips_pkg::OP_XORI, 5'd2, 5'd13, 16'ha5a5), 2);
      put(itype(mips_pkg::OP_SLTI, 5'd2, 5'd14, 16'h0001), 2);
      for (int k = 0; k < 8; k++)
         put(rtype(fns[k], 5'd2, 5'd1, 5'(4 + k), 5'd0), 2);
      for (int k = 1; k <= 14; k++)
         keep(5'(k), 2);
      // shifts and lui
      put(itype(mips_pkg::OP_LUI, 5'd0, 5'd15, 16'h8765), 3);
      put(itype(mips_pkg::OP_ORI, 5'd15, 5'd15, 16'h4321), 3);
      put(itype(mips_pkg::OP_ADDIU, 5'd0, 5'd19, 16'h002d), 3);   // low bits give 13
      put(rtype(mips_pkg::FN_SLL, 5'd0, 5'd15, 5'd16, 5'd4), 3);
      put(rtype(mips_pkg::FN_SRL, 5'd0, 5'd15, 5'd17, 5'd7), 3);
      put(rtype(mips_pkg::FN_SRA, 5'd0, 5'd15, 5'd18, 5'd9), 3);
      put(rtype(mips_pkg::FN_SLLV, 5'd19, 5'd15, 5'd20, 5'd0), 3);
      put(rtype(mips_pkg::FN_SRLV, 5'd19, 5'd15, 5'd21, 5'd0), 3);
      put(rtype(mips_pkg::FN_SRAV, 5'd19, 5'd15, 5'd22, 5'd0), 3);
      for (int k = 15; k <= 22; k++)
         keep(5'(k), 3);
      // partial stores into words 40 to 45 and read back through lw
      put(itype(mips_pkg::OP_ADDIU, 5'd0, 5'd23, 16'ha5c3), 4);
      for (int k = 0; k < 4; k++)
         put(itype(mips_pkg::OP_SB, 5'd0, 5'd23, 16'(160 + 5 * k)), 4);   // offset k in word 40+k
      put(itype(mips_pkg::OP_SH, 5'd0, 5'd23, 16'd176), 4);
      put(itype(mips_pkg::OP_SH, 5'd0, 5'd23, 16'd182), 4);
      for (int k = 0; k < 6; k++)
      begin
         put(itype(mips_pkg::OP_LW, 5'd0, 5'd24, 16'(160 + 4 * k)), 4);
         keep(5'd24, 4);
      end
      // loads from lfsr words 48 and up
      put(itype(mips_pkg::OP_LB, 5'd0, 5'd25, 16'd193), 5);
      put(itype(mips_pkg::OP_LB, 5'd0, 5'd26, 16'd198), 5);
      put(itype(mips_pkg::OP_LBU, 5'd0, 5'd27, 16'd195), 5);
      put(itype(mips_pkg::OP_LH, 5'd0, 5'd28, 16'd194), 5);
      put(itype(mips_pkg::OP_LH, 5'd0, 5'd29, 16'd200), 5);
      put(itype(mips_pkg::OP_LHU, 5'd0, 5'd30, 16'd206), 5);
      put(itype(mips_pkg::OP_LW, 5'd0, 5'd31, 16'd208), 5);
      for (int k = 25; k <= 31; k++)
         keep(5'(k), 5);
      for (int i = 0; i < MEM_WORDS; i++)
         model_mem[i] = mem[i];
      run_model();
      built = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_value(1, "mem_write_en", 32'd0, {28'd0, mem_write_en});
      check_value(1, "inst_addr", {2'b00, BASE_WA}, {2'b00, inst_addr});
      rst_b = 1'b1;
      @(posedge clk);
      run = 1'b1;
      repeat (n_prog + 6) @(negedge clk);
      @(posedge clk);   // last falling edge check is done before the window closes
      run = 1'b0;
      if (p < n_exp)
      begin
         $display("%0d expected stores never appeared on the memory port", n_exp - p);
         err[6] += n_exp - p;
      end
      total_chk = 0;
      total_err = 0;
      for (int t = 1; t <= 6; t++)
      begin
         $display("test %0d: %0d checks, %0d errors", t, chk[t], err[t]);
         total_chk += chk[t];
         total_err += err[t];
      end
      $display("checks %0d, errors %0d, stores %0d of %0d", total_chk, total_err, p, n_exp);
      if (total_err == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// ==== tb/mips_core_sva.sv ====
`timescale 1ns/10ps

module mips_core_sva (
   input logic                  clk,
   input logic                  rst_b,
   input mips_pkg::waddr_t      inst_addr,
   input mips_pkg::byte_en_t    mem_write_en
);

   // nothing may be written while the core sits in reset
   no_write_in_reset: assert property (@(posedge clk) !rst_b |-> (mem_write_en == 4'b0000))
      else $error("memory write enable active during reset");

   // one byte, an aligned half, a full word, or nothing
   legal_lanes: assert property (@(posedge clk) disable iff (!rst_b)
      mem_write_en inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                           4'b0011, 4'b1100, 4'b1111})
      else $error("illegal byte lane pattern %b", mem_write_en);

   // fetch never stalls
   fetch_steps: assert property (@(posedge clk) disable iff (!rst_b)
      $past(rst_b) |-> (inst_addr == $past(inst_addr) + 30'd1))
      else $error("instruction address did not step by one");

endmodule

// ==== rtl/mips_core.sv ====
`timescale 1ns/10ps

module mips_core (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::word_t    inst,
   input  mips_pkg::word_t    mem_data_out,
   output mips_pkg::waddr_t   inst_addr,
   output mips_pkg::waddr_t   mem_addr,
   output mips_pkg::word_t    mem_data_in,
   output mips_pkg::byte_en_t mem_write_en
);

   // fetch and id stage
   mips_pkg::waddr_t   pc;
   mips_pkg::word_t    inst_id;

   // decode outputs
   mips_pkg::reg_idx_t dec_rs;
   mips_pkg::reg_idx_t dec_rt;
   mips_pkg::reg_idx_t dec_rd;
   mips_pkg::alu_op_t  dec_alu_op;
   mips_pkg::mem_op_t  dec_mem_op;
   logic               dec_use_imm;
   logic               dec_reg_we;
   mips_pkg::word_t    dec_imm_ext;
   mips_pkg::word_t    rs_data;
   mips_pkg::word_t    rt_data;

   // ex stage
   mips_pkg::alu_op_t  alu_op_ex;
   mips_pkg::mem_op_t  mem_op_ex;
   logic               use_imm_ex;
   logic               reg_we_ex;
   mips_pkg::reg_idx_t wr_idx_ex;
   mips_pkg::word_t    rs_data_ex;
   mips_pkg::word_t    rt_data_ex;
   mips_pkg::word_t    imm_ex;
   mips_pkg::word_t    alu_b;
   mips_pkg::word_t    alu_result;

   // mem stage
   mips_pkg::mem_op_t  mem_op_mem;
   logic               reg_we_mem;
   mips_pkg::reg_idx_t wr_idx_mem;
   mips_pkg::word_t    alu_mem;
   mips_pkg::word_t    rt_mem;
   mips_pkg::word_t    load_value;
   logic               wb_load;
   mips_pkg::word_t    wb_data;

   // wb stage
   logic               reg_we_wb;
   mips_pkg::reg_idx_t wr_idx_wb;
   mips_pkg::word_t    wb_data_wb;

   // fetch steps every cycle, all-zero inst_id is sll r0 and writes nothing
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc      <= mips_pkg::RESET_PC[31:2];
         inst_id <= '0;
      end
      else
      begin
         pc      <= pc + 30'd1;
         inst_id <= inst;   // edge E0
      end
   end

   assign inst_addr = pc;

   mips_decode decode0 (.inst(inst_id), .rs(dec_rs), .rt(dec_rt), .rd(dec_rd),
                        .alu_op(dec_alu_op), .mem_op(dec_mem_op), .use_imm(dec_use_imm),
                        .reg_we(dec_reg_we), .imm_ext(dec_imm_ext));

   mips_regfile regfile0 (.clk(clk), .rst_b(rst_b), .rs_idx(dec_rs), .rt_idx(dec_rt),
                          .wr_idx(wr_idx_wb), .wr_data(wb_data_wb), .wr_en(reg_we_wb),
                          .rs_data(rs_data), .rt_data(rt_data));

   // pipeline control, cleared to a no-op
   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         alu_op_ex  <= mips_pkg::ALU_ADD;
         mem_op_ex  <= mips_pkg::MEM_NONE;
         use_imm_ex <= 1'b0;
         reg_we_ex  <= 1'b0;
         wr_idx_ex  <= '0;
         mem_op_mem <= mips_pkg::MEM_NONE;
         reg_we_mem <= 1'b0;
         wr_idx_mem <= '0;
         reg_we_wb  <= 1'b0;
         wr_idx_wb  <= '0;
      end
      else
      begin
         alu_op_ex  <= dec_alu_op;   // E1
         mem_op_ex  <= dec_mem_op;
         use_imm_ex <= dec_use_imm;
         reg_we_ex  <= dec_reg_we;
         wr_idx_ex  <= dec_rd;
         mem_op_mem <= mem_op_ex;    // E2
         reg_we_mem <= reg_we_ex;
         wr_idx_mem <= wr_idx_ex;
         reg_we_wb  <= reg_we_mem;   // E3, regfile write at E4
         wr_idx_wb  <= wr_idx_mem;
      end
   end

   // datapath registers
   always_ff @(posedge clk)
   begin
      rs_data_ex <= rs_data;
      rt_data_ex <= rt_data;
      imm_ex     <= dec_imm_ext;
      alu_mem    <= alu_result;
      rt_mem     <= rt_data_ex;   // store source
      wb_data_wb <= wb_data;
   end

   assign alu_b = use_imm_ex ? imm_ex : rt_data_ex;

   mips_alu alu0 (.op_a(rs_data_ex), .op_b(alu_b), .op(alu_op_ex),
                  .shamt(imm_ex[10:6]), .result(alu_result));

   mips_mem_align align0 (.mem_op(mem_op_mem), .byte_addr_lo(alu_mem[1:0]),
                          .store_src(rt_mem), .rd_word(mem_data_out), .wr_word(mem_data_in),
                          .wr_en(mem_write_en), .load_value(load_value));

   assign mem_addr = alu_mem[31:2];

   // writeback select
   assign wb_load = mem_op_mem inside {mips_pkg::MEM_LB, mips_pkg::MEM_LBU, mips_pkg::MEM_LH,
                                       mips_pkg::MEM_LHU, mips_pkg::MEM_LW};
   assign wb_data = wb_load ? load_value : alu_mem;

endmodule

// ==== rtl/mips_mem_align.sv ====
`timescale 1ns/10ps

module mips_mem_align (
   input  mips_pkg::mem_op_t  mem_op,
   input  logic [1:0]         byte_addr_lo,  // byte offset in the word
   input  mips_pkg::word_t    store_src,     // rt data
   input  mips_pkg::word_t    rd_word,       // word read from memory
   output mips_pkg::word_t    wr_word,
   output mips_pkg::byte_en_t wr_en,
   output mips_pkg::word_t    load_value
);

   logic [4:0]  lane_shift;   // offset times 8
   logic [4:0]  half_shift;   // 0 or 16
   logic [1:0]  half_lane;
   logic [7:0]  ld_byte;
   logic [15:0] ld_half;

   assign lane_shift = {byte_addr_lo, 3'b000};
   assign half_shift = {byte_addr_lo[1], 4'b0000};
   assign half_lane  = {byte_addr_lo[1], 1'b0};   // halves sit at lane 0 or 2

   // store side, little endian lanes
   always_comb
   begin
      wr_word = store_src;
      wr_en   = 4'b0000;
      case (mem_op)
         mips_pkg::MEM_SB:
         begin
            wr_word = {24'd0, store_src[7:0]} << lane_shift;
            wr_en   = 4'b0001 << byte_addr_lo;
         end
         mips_pkg::MEM_SH:
         begin
            wr_word = {16'd0, store_src[15:0]} << half_shift;
            wr_en   = 4'b0011 << half_lane;
         end
         mips_pkg::MEM_SW: wr_en = 4'b1111;
         default:          wr_en = 4'b0000;   // loads and non-memory ops never write
      endcase
   end

   assign ld_byte = rd_word[lane_shift +: 8];
   assign ld_half = rd_word[half_shift +: 16];

   // load side, extract and extend
   always_comb
   begin
      case (mem_op)
         mips_pkg::MEM_LB:  load_value = {{24{ld_byte[7]}}, ld_byte};
         mips_pkg::MEM_LBU: load_value = {24'd0, ld_byte};
         mips_pkg::MEM_LH:  load_value = {{16{ld_half[15]}}, ld_half};
         mips_pkg::MEM_LHU: load_value = {16'd0, ld_half};
         default:           load_value = rd_word;   // lw takes the whole word
      endcase
   end

endmodule

// ==== rtl/mips_alu.sv ====
`timescale 1ns/10ps

module mips_alu (
   input  mips_pkg::word_t   op_a,    // rs data
   input  mips_pkg::word_t   op_b,    // rt data or extended immediate
   input  mips_pkg::alu_op_t op,
   input  logic [4:0]        shamt,   // inst[10:6]
   output mips_pkg::word_t   result
);

   logic [4:0] var_amt;
   logic       lt_signed;
   logic       lt_unsigned;

   assign var_amt     = op_a[4:0];   // variable shifts use rs low bits
   assign lt_signed   = ($signed(op_a) < $signed(op_b));
   assign lt_unsigned = (op_a < op_b);

   always_comb
   begin
      case (op)
         mips_pkg::ALU_ADD:  result = op_a + op_b;   // no overflow trap
         mips_pkg::ALU_SUB:  result = op_a - op_b;
         mips_pkg::ALU_AND:  result = op_a & op_b;
         mips_pkg::ALU_OR:   result = op_a | op_b;
         mips_pkg::ALU_XOR:  result = op_a ^ op_b;
         mips_pkg::ALU_NOR:  result = ~(op_a | op_b);
         mips_pkg::ALU_SLT:  result = {31'd0, lt_signed};
         mips_pkg::ALU_SLTU: result = {31'd0, lt_unsigned};
         // constant shifts move rt by shamt
         mips_pkg::ALU_SLL:  result = op_b << shamt;
         mips_pkg::ALU_SRL:  result = op_b >> shamt;
         mips_pkg::ALU_SRA:  result = $signed(op_b) >>> shamt;
         mips_pkg::ALU_SLLV: result = op_b << var_amt;
         mips_pkg::ALU_SRLV: result = op_b >> var_amt;
         mips_pkg::ALU_SRAV: result = $signed(op_b) >>> var_amt;
         mips_pkg::ALU_LUI:  result = {op_b[15:0], 16'h0000};
         default:            result = '0;
      endcase
   end

endmodule

// ==== rtl/mips_regfile.sv ====
`timescale 1ns/10ps

module mips_regfile (
   input  logic               clk,
   input  logic               rst_b,
   input  mips_pkg::reg_idx_t rs_idx,
   input  mips_pkg::reg_idx_t rt_idx,
   input  mips_pkg::reg_idx_t wr_idx,
   input  mips_pkg::word_t    wr_data,
   input  logic               wr_en,
   output mips_pkg::word_t    rs_data,
   output mips_pkg::word_t    rt_data
);

   mips_pkg::word_t regs [1:31];   // r0 has no storage

   // one read port, r0 reads zero and a same-cycle write bypasses the array
   function automatic mips_pkg::word_t read_port(mips_pkg::reg_idx_t idx);
      if (idx == 5'd0)
         return '0;
      else if (wr_en && (idx == wr_idx))
         return wr_data;
      else
         return regs[idx];
   endfunction

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end
      else if (wr_en && (wr_idx != 5'd0))
         regs[wr_idx] <= wr_data;
   end

   always_comb
   begin
      rs_data = read_port(rs_idx);
      rt_data = read_port(rt_idx);
   end

endmodule

// ==== rtl/mips_decode.sv ====
`timescale 1ns/10ps

module mips_decode (
   input  mips_pkg::word_t    inst,
   output mips_pkg::reg_idx_t rs,
   output mips_pkg::reg_idx_t rt,
   output mips_pkg::reg_idx_t rd,       // destination register
   output mips_pkg::alu_op_t  alu_op,
   output mips_pkg::mem_op_t  mem_op,
   output logic               use_imm,  // alu operand b from immediate
   output logic               reg_we,
   output mips_pkg::word_t    imm_ext
);

   logic [5:0]      opcode;
   logic [5:0]      funct;
   mips_pkg::imm_t  imm;
   logic            is_rtype;
   logic            sign_ext;

   assign opcode = inst[31:26];
   assign funct  = inst[5:0];
   assign imm    = inst[15:0];
   assign rs     = inst[25:21];
   assign rt     = inst[20:16];

   assign is_rtype = (opcode == mips_pkg::OP_SPECIAL);
   assign use_imm  = !is_rtype;  // every kept i-type feeds the immediate to the alu
   assign rd       = is_rtype ? inst[15:11] : inst[20:16];

   // logic immediates are zero extended, the rest sign extended
   assign sign_ext = !(opcode inside {mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI});
   assign imm_ext  = sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};

   always_comb
   begin
      alu_op = mips_pkg::ALU_ADD;   // loads and stores add base and offset
      mem_op = mips_pkg::MEM_NONE;
      reg_we = 1'b1;
      case (opcode)
         mips_pkg::OP_SPECIAL:
         begin
            case (funct)
               mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_NOR:  alu_op = mips_pkg::ALU_NOR;
               mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLTU: alu_op = mips_pkg::ALU_SLTU;
               mips_pkg::FN_SLL:  alu_op = mips_pkg::ALU_SLL;
               mips_pkg::FN_SRL:  alu_op = mips_pkg::ALU_SRL;
               mips_pkg::FN_SRA:  alu_op = mips_pkg::ALU_SRA;
               mips_pkg::FN_SLLV: alu_op = mips_pkg::ALU_SLLV;
               mips_pkg::FN_SRLV: alu_op = mips_pkg::ALU_SRLV;
               mips_pkg::FN_SRAV: alu_op = mips_pkg::ALU_SRAV;
               default:           reg_we = 1'b0;   // unknown funct is a no-op
            endcase
         end
         mips_pkg::OP_ADDIU: alu_op = mips_pkg::ALU_ADD;
         mips_pkg::OP_SLTI:  alu_op = mips_pkg::ALU_SLT;
         mips_pkg::OP_ANDI:  alu_op = mips_pkg::ALU_AND;
         mips_pkg::OP_ORI:   alu_op = mips_pkg::ALU_OR;
         mips_pkg::OP_XORI:  alu_op = mips_pkg::ALU_XOR;
         mips_pkg::OP_LUI:   alu_op = mips_pkg::ALU_LUI;
         // loads write rt with the extended memory value
         mips_pkg::OP_LB:    mem_op = mips_pkg::MEM_LB;
         mips_pkg::OP_LBU:   mem_op = mips_pkg::MEM_LBU;
         mips_pkg::OP_LH:    mem_op = mips_pkg::MEM_LH;
         mips_pkg::OP_LHU:   mem_op = mips_pkg::MEM_LHU;
         mips_pkg::OP_LW:    mem_op = mips_pkg::MEM_LW;
         mips_pkg::OP_SB:
         begin
            mem_op = mips_pkg::MEM_SB;
            reg_we = 1'b0;
         end
         mips_pkg::OP_SH:
         begin
            mem_op = mips_pkg::MEM_SH;
            reg_we = 1'b0;
         end
         mips_pkg::OP_SW:
         begin
            mem_op = mips_pkg::MEM_SW;
            reg_we = 1'b0;
         end
         default: reg_we = 1'b0;   // opcode not kept
      endcase
   end

endmodule

// ==== rtl/mips_pkg.sv ====
package mips_pkg;

   typedef logic [31:0] word_t;     // register and memory data word
   typedef logic [29:0] waddr_t;    // word address, byte address bits 31:2
   typedef logic [4:0]  reg_idx_t;  // register number
   typedef logic [15:0] imm_t;      // raw immediate field
   typedef logic [3:0]  alu_op_t;
   typedef logic [3:0]  mem_op_t;   // 9 codes, needs the fourth bit
   typedef logic [3:0]  byte_en_t;  // bit k enables bits 8k+7 down to 8k

   localparam word_t RESET_PC = 32'h0040_0000;  // byte address of the first fetch

   // primary opcodes, inst[31:26]
   localparam logic [5:0] OP_SPECIAL = 6'h00;
   localparam logic [5:0] OP_ADDIU   = 6'h09;
   localparam logic [5:0] OP_SLTI    = 6'h0a;
   localparam logic [5:0] OP_ANDI    = 6'h0c;
   localparam logic [5:0] OP_ORI     = 6'h0d;
   localparam logic [5:0] OP_XORI    = 6'h0e;
   localparam logic [5:0] OP_LUI     = 6'h0f;
   localparam logic [5:0] OP_LB      = 6'h20;
   localparam logic [5:0] OP_LH      = 6'h21;
   localparam logic [5:0] OP_LW      = 6'h23;
   localparam logic [5:0] OP_LBU     = 6'h24;
   localparam logic [5:0] OP_LHU     = 6'h25;
   localparam logic [5:0] OP_SB      = 6'h28;
   localparam logic [5:0] OP_SH      = 6'h29;
   localparam logic [5:0] OP_SW      = 6'h2b;

   // funct codes under OP_SPECIAL, inst[5:0]
   localparam logic [5:0] FN_SLL  = 6'h00;
   localparam logic [5:0] FN_SRL  = 6'h02;
   localparam logic [5:0] FN_SRA  = 6'h03;
   localparam logic [5:0] FN_SLLV = 6'h04;
   localparam logic [5:0] FN_SRLV = 6'h06;
   localparam logic [5:0] FN_SRAV = 6'h07;
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUBU = 6'h23;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_XOR  = 6'h26;
   localparam logic [5:0] FN_NOR  = 6'h27;
   localparam logic [5:0] FN_SLT  = 6'h2a;
   localparam logic [5:0] FN_SLTU = 6'h2b;

   // alu operations
   localparam alu_op_t ALU_ADD  = 4'd0;   // also address generation
   localparam alu_op_t ALU_SUB  = 4'd1;
   localparam alu_op_t ALU_AND  = 4'd2;
   localparam alu_op_t ALU_OR   = 4'd3;
   localparam alu_op_t ALU_XOR  = 4'd4;
   localparam alu_op_t ALU_NOR  = 4'd5;
   localparam alu_op_t ALU_SLT  = 4'd6;
   localparam alu_op_t ALU_SLTU = 4'd7;
   localparam alu_op_t ALU_SLL  = 4'd8;
   localparam alu_op_t ALU_SRL  = 4'd9;
   localparam alu_op_t ALU_SRA  = 4'd10;
   localparam alu_op_t ALU_SLLV = 4'd11;
   localparam alu_op_t ALU_SRLV = 4'd12;
   localparam alu_op_t ALU_SRAV = 4'd13;
   localparam alu_op_t ALU_LUI  = 4'd14;

   // memory operations
   localparam mem_op_t MEM_NONE = 4'd0;
   localparam mem_op_t MEM_LB   = 4'd1;
   localparam mem_op_t MEM_LBU  = 4'd2;
   localparam mem_op_t MEM_LH   = 4'd3;
   localparam mem_op_t MEM_LHU  = 4'd4;
   localparam mem_op_t MEM_LW   = 4'd5;
   localparam mem_op_t MEM_SB   = 4'd6;
   localparam mem_op_t MEM_SH   = 4'd7;
   localparam mem_op_t MEM_SW   = 4'd8;

endpackage
